// File: fetch_pkg.sv
/* fetch front end shared types */

package fetch_pkg;

    // ------------------------------
    // widths and sizes
    // ------------------------------
    localparam int unsigned XLEN        = 32;
    localparam int unsigned BHT_ENTRIES = 16;
    localparam int unsigned BHT_IDX_W   = 4;
    localparam int unsigned QUEUE_DEPTH = 4;
    // queue pointer width, log2 of QUEUE_DEPTH
    localparam int unsigned QUEUE_PTR_W = 2;

    typedef logic [XLEN-1:0]        addr_t;
    typedef logic [XLEN-1:0]        instr_t;
    typedef logic [BHT_IDX_W-1:0]   bht_idx_t;
    typedef logic [1:0]             bht_cnt_t;
    typedef logic [6:0]             opcode_t;
    typedef logic [QUEUE_PTR_W-1:0] qptr_t;
    // one extra bit so a full queue is distinct from an empty one
    typedef logic [QUEUE_PTR_W:0]   qcnt_t;

    // rv32i control flow opcodes
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;

    // counter values for the first write and the saturation limit
    localparam bht_cnt_t BHT_CNT_INIT_TAKEN     = 2'd2;
    localparam bht_cnt_t BHT_CNT_INIT_NOT_TAKEN = 2'd1;
    localparam bht_cnt_t BHT_CNT_MAX            = 2'd3;
    localparam bht_cnt_t BHT_CNT_MIN            = 2'd0;

    // ------------------------------
    // bundles
    // ------------------------------
    typedef struct packed {
        logic  req;
        addr_t addr;
    } imem_req_t;

    typedef struct packed {
        logic   valid;
        instr_t data;
    } imem_rsp_t;

    // resolved control flow from the back end
    typedef struct packed {
        logic  valid;
        logic  is_branch;
        logic  taken;
        logic  is_mispredict;
        addr_t pc;
        addr_t target;
    } bp_resolve_t;

    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

    typedef struct packed {
        addr_t  pc;
        instr_t instr;
        logic   pred_taken;
        addr_t  pred_target;
    } fetch_entry_t;

endpackage

// File: fetch_pc_gen.sv
/* next pc generation */

`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  fetch_pkg::addr_t       boot_addr_i,
    input  fetch_pkg::addr_t       epc_i,
    input  fetch_pkg::addr_t       trap_vector_base_i,
    input  fetch_pkg::addr_t       pc_commit_i,
    input  logic                   eret_i,
    input  logic                   ex_valid_i,
    input  logic                   set_pc_commit_i,
    input  fetch_pkg::bp_resolve_t resolved_branch_i,
    input  logic                   room_i,
    input  logic                   pred_taken_i,
    input  fetch_pkg::addr_t       pred_target_i,
    input  logic                   rsp_valid_i,
    output fetch_pkg::imem_req_t   imem_req_o,
    output logic                   accept_o,
    output fetch_pkg::addr_t       fetch_pc_o,
    output logic                   redirect_o
);
    logic             mispredict;
    logic             take_pred;
    logic             req;
    // set out of reset so the first request uses boot_addr_i
    logic             npc_rst_load_q;
    fetch_pkg::addr_t npc_d;
    fetch_pkg::addr_t npc_q;
    fetch_pkg::addr_t fetch_addr;
    // one response in flight at most
    logic             pending_q;
    fetch_pkg::addr_t pending_addr_q;

    assign mispredict = resolved_branch_i.valid & resolved_branch_i.is_mispredict;
    assign redirect_o = mispredict | eret_i | ex_valid_i | set_pc_commit_i;

    // response only counts if still wanted and no redirect kills it now
    assign accept_o   = pending_q & rsp_valid_i & ~redirect_o;
    assign fetch_pc_o = pending_addr_q;
    assign take_pred  = accept_o & pred_taken_i;

    // quiet in reset, and no request in a redirect cycle, new path starts next cycle
    assign req = rst_ni & room_i & ~redirect_o;

    assign imem_req_o.req  = req;
    assign imem_req_o.addr = fetch_addr;

    // ------------------------------
    // npc select, last one wins
    // ------------------------------
    always_comb begin
        if (npc_rst_load_q) begin
            fetch_addr = boot_addr_i;
        end else begin
            fetch_addr = npc_q;
        end
        // taken prediction steers the request issued this same cycle
        if (take_pred) begin
            fetch_addr = pred_target_i;
        end
        npc_d = fetch_addr;
        if (req) begin
            npc_d = fetch_addr + fetch_pkg::addr_t'(4);
        end
        if (mispredict) begin
            npc_d = resolved_branch_i.target;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_vector_base_i;
        end
        // csr side effect flush, restart after the committing instruction
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + fetch_pkg::addr_t'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_rst_load_q <= 1'b1;
            npc_q          <= '0;
            pending_q      <= 1'b0;
        end else begin
            npc_rst_load_q <= 1'b0;
            npc_q          <= npc_d;
            // redirect drops req, so this also clears the flag
            pending_q      <= req;
        end
    end

    // address of the word due back next cycle
    always_ff @(posedge clk_i) begin
        if (req) begin
            pending_addr_q <= fetch_addr;
        end
    end

endmodule

// File: cf_predict.sv
/* control flow pre-decode and prediction */

`timescale 1ns/1ps

module cf_predict (
    input  fetch_pkg::instr_t    instr_i,
    input  fetch_pkg::addr_t     pc_i,
    input  fetch_pkg::bht_pred_t bht_i,
    output logic                 pred_taken_o,
    output fetch_pkg::addr_t     pred_target_o
);
    logic             is_branch;
    logic             is_jal;
    fetch_pkg::addr_t imm_b;
    fetch_pkg::addr_t imm_j;
    fetch_pkg::addr_t offset;

    // ------------------------------
    // pre-decode
    // ------------------------------
    assign is_branch = (instr_i[6:0] == fetch_pkg::OPCODE_BRANCH);
    assign is_jal    = (instr_i[6:0] == fetch_pkg::OPCODE_JAL);

    // b-type immediate, bit 0 is implied zero
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    // j-type immediate
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // ------------------------------
    // direction and target
    // ------------------------------
    always_comb begin
        // plain word falls through to pc+4
        pred_taken_o = 1'b0;
        offset       = fetch_pkg::addr_t'(4);
        if (is_jal) begin
            // unconditional, target known from the word itself
            pred_taken_o = 1'b1;
            offset       = imm_j;
        end else if (is_branch) begin
            if (bht_i.valid) begin
                pred_taken_o = bht_i.taken;
            end else begin
                // static rule, backward taken and forward not taken
                pred_taken_o = imm_b[fetch_pkg::XLEN-1];
            end
            if (pred_taken_o) begin
                offset = imm_b;
            end
        end
    end

    // single adder serves both taken target and fall through
    assign pred_target_o = pc_i + offset;

endmodule

// File: branch_history.sv
/* branch history table */

`timescale 1ns/1ps

module branch_history (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  fetch_pkg::addr_t       lookup_pc_i,
    input  fetch_pkg::bp_resolve_t resolved_branch_i,
    output fetch_pkg::bht_pred_t   pred_o
);
    logic [fetch_pkg::BHT_ENTRIES-1:0] valid_q;
    fetch_pkg::bht_cnt_t               cnt_q [fetch_pkg::BHT_ENTRIES];
    fetch_pkg::bht_idx_t               lookup_idx;
    fetch_pkg::bht_idx_t               update_idx;
    logic                              update;

    // word aligned pc, drop the two low bits
    assign lookup_idx = lookup_pc_i[fetch_pkg::BHT_IDX_W+1:2];
    assign update_idx = resolved_branch_i.pc[fetch_pkg::BHT_IDX_W+1:2];

    // only conditional branches train the table
    assign update = resolved_branch_i.valid & resolved_branch_i.is_branch;

    // ------------------------------
    // lookup
    // ------------------------------
    assign pred_o.valid = valid_q[lookup_idx];
    // msb of the counter is the direction
    assign pred_o.taken = valid_q[lookup_idx] & cnt_q[lookup_idx][1];

    // ------------------------------
    // update
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (update) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update) begin
            if (!valid_q[update_idx]) begin
                // first sighting starts in the weak state of the outcome
                cnt_q[update_idx] <= resolved_branch_i.taken ?
                                     fetch_pkg::BHT_CNT_INIT_TAKEN :
                                     fetch_pkg::BHT_CNT_INIT_NOT_TAKEN;
            end else if (resolved_branch_i.taken) begin
                if (cnt_q[update_idx] != fetch_pkg::BHT_CNT_MAX) begin
                    cnt_q[update_idx] <= cnt_q[update_idx] + fetch_pkg::bht_cnt_t'(1);
                end
            end else begin
                if (cnt_q[update_idx] != fetch_pkg::BHT_CNT_MIN) begin
                    cnt_q[update_idx] <= cnt_q[update_idx] - fetch_pkg::bht_cnt_t'(1);
                end
            end
        end
    end

endmodule

// File: fetch_queue.sv
/* fetch entry queue */

`timescale 1ns/1ps

module fetch_queue (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    output logic                    room_o,
    output fetch_pkg::fetch_entry_t fetch_entry_o,
    output logic                    fetch_entry_valid_o,
    input  logic                    fetch_entry_ready_i
);
    fetch_pkg::fetch_entry_t mem_q [fetch_pkg::QUEUE_DEPTH];
    fetch_pkg::qptr_t        rd_ptr_q;
    fetch_pkg::qptr_t        wr_ptr_q;
    fetch_pkg::qcnt_t        count_q;
    logic                    pop;

    // head of the queue goes straight out
    assign fetch_entry_valid_o = (count_q != '0);
    assign fetch_entry_o       = mem_q[rd_ptr_q];
    assign pop                 = fetch_entry_valid_o & fetch_entry_ready_i;

    // two free slots, one held back for the response already in flight
    assign room_o = (count_q <= fetch_pkg::qcnt_t'(fetch_pkg::QUEUE_DEPTH - 2));

    // ------------------------------
    // pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // redirect drops every queued entry
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // depth is a power of two, pointers wrap on their own
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + fetch_pkg::qptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + fetch_pkg::qptr_t'(1);
            end
            case ({push_i, pop})
                2'b10: begin
                    count_q <= count_q + fetch_pkg::qcnt_t'(1);
                end
                2'b01: begin
                    count_q <= count_q - fetch_pkg::qcnt_t'(1);
                end
                default: begin
                    count_q <= count_q;
                end
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i && !flush_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

// File: fetch_frontend.sv
/* instruction fetch front end */

`timescale 1ns/1ps

module fetch_frontend (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  fetch_pkg::addr_t        boot_addr_i,
    input  fetch_pkg::addr_t        epc_i,
    input  fetch_pkg::addr_t        trap_vector_base_i,
    input  fetch_pkg::addr_t        pc_commit_i,
    input  logic                    eret_i,
    input  logic                    ex_valid_i,
    input  logic                    set_pc_commit_i,
    input  fetch_pkg::bp_resolve_t  resolved_branch_i,
    output fetch_pkg::imem_req_t    imem_req_o,
    input  fetch_pkg::imem_rsp_t    imem_rsp_i,
    output fetch_pkg::fetch_entry_t fetch_entry_o,
    output logic                    fetch_entry_valid_o,
    input  logic                    fetch_entry_ready_i
);
    fetch_pkg::addr_t        fetch_pc;
    logic                    accept;
    logic                    redirect;
    logic                    room;
    logic                    pred_taken;
    fetch_pkg::addr_t        pred_target;
    fetch_pkg::bht_pred_t    bht_pred;
    fetch_pkg::fetch_entry_t push_entry;

    // entry for the word accepted this cycle
    assign push_entry.pc          = fetch_pc;
    assign push_entry.instr       = imem_rsp_i.data;
    assign push_entry.pred_taken  = pred_taken;
    assign push_entry.pred_target = pred_target;

    fetch_pc_gen i_pc_gen (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .boot_addr_i        (boot_addr_i),
        .epc_i              (epc_i),
        .trap_vector_base_i (trap_vector_base_i),
        .pc_commit_i        (pc_commit_i),
        .eret_i             (eret_i),
        .ex_valid_i         (ex_valid_i),
        .set_pc_commit_i    (set_pc_commit_i),
        .resolved_branch_i  (resolved_branch_i),
        .room_i             (room),
        .pred_taken_i       (pred_taken),
        .pred_target_i      (pred_target),
        .rsp_valid_i        (imem_rsp_i.valid),
        .imem_req_o         (imem_req_o),
        .accept_o           (accept),
        .fetch_pc_o         (fetch_pc),
        .redirect_o         (redirect)
    );

    cf_predict i_cf_predict (
        .instr_i       (imem_rsp_i.data),
        .pc_i          (fetch_pc),
        .bht_i         (bht_pred),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    branch_history i_bht (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .lookup_pc_i       (fetch_pc),
        .resolved_branch_i (resolved_branch_i),
        .pred_o            (bht_pred)
    );

    fetch_queue i_queue (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (redirect),
        .push_i              (accept),
        .entry_i             (push_entry),
        .room_o              (room),
        .fetch_entry_o       (fetch_entry_o),
        .fetch_entry_valid_o (fetch_entry_valid_o),
        .fetch_entry_ready_i (fetch_entry_ready_i)
    );

endmodule

// File: fetch_frontend_checker.sv
/* fetch front end port checks */

`timescale 1ns/1ps

module fetch_frontend_checker (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    push_i,
    input logic                    flush_i,
    input fetch_pkg::imem_req_t    imem_req_o,
    input fetch_pkg::fetch_entry_t fetch_entry_o,
    input logic                    fetch_entry_valid_o,
    input logic                    fetch_entry_ready_i
);
    // read back by the testbench at the end of the run
    int unsigned fail_count = 0;
    int unsigned occupancy;
    logic        pop;

    assign pop = fetch_entry_valid_o & fetch_entry_ready_i;

    // shadow occupancy of the queue
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            occupancy <= 0;
        end else if (flush_i) begin
            occupancy <= 0;
        end else if (push_i && !pop) begin
            occupancy <= occupancy + 1;
        end else if (!push_i && pop) begin
            occupancy <= occupancy - 1;
        end
    end

    // nothing requested or offered while in reset
    reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !fetch_entry_valid_o && !imem_req_o.req)
        else begin
            fail_count++;
            $error("valid output high during reset");
        end

    // a stalled entry holds until it transfers or a redirect drops it
    entry_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_entry_valid_o && !fetch_entry_ready_i && !flush_i
        |=> fetch_entry_valid_o && $stable(fetch_entry_o))
        else begin
            fail_count++;
            $error("fetch entry changed while stalled");
        end

    no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i && !pop |-> occupancy < fetch_pkg::QUEUE_DEPTH)
        else begin
            fail_count++;
            $error("push into a full fetch queue");
        end

endmodule

bind fetch_frontend fetch_frontend_checker u_checker (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .push_i              (accept),
    .flush_i             (redirect),
    .imem_req_o          (imem_req_o),
    .fetch_entry_o       (fetch_entry_o),
    .fetch_entry_valid_o (fetch_entry_valid_o),
    .fetch_entry_ready_i (fetch_entry_ready_i)
);

// File: tb_fetch_frontend.sv
/* fetch front end testbench */

`timescale 1ns/1ps

module tb_fetch_frontend;

    logic                    clk_i;
    logic                    rst_ni;
    fetch_pkg::addr_t        boot_addr_i;
    fetch_pkg::addr_t        epc_i;
    fetch_pkg::addr_t        trap_vector_base_i;
    fetch_pkg::addr_t        pc_commit_i;
    logic                    eret_i;
    logic                    ex_valid_i;
    logic                    set_pc_commit_i;
    fetch_pkg::bp_resolve_t  resolved_branch_i;
    fetch_pkg::imem_req_t    imem_req_o;
    fetch_pkg::imem_rsp_t    imem_rsp_i;
    fetch_pkg::fetch_entry_t fetch_entry_o;
    logic                    fetch_entry_valid_o;
    logic                    fetch_entry_ready_i;

    // reference state
    logic                    model_valid [fetch_pkg::BHT_ENTRIES];
    int                      model_cnt [fetch_pkg::BHT_ENTRIES];
    fetch_pkg::fetch_entry_t exp_e;
    logic [31:0]             lcg_state;
    logic                    random_ready;
    logic                    timed_out;
    logic                    first_req_done;
    int unsigned             xfer_count;
    int unsigned             errors;
    // memory model capture
    logic                    mem_req_seen;
    fetch_pkg::addr_t        mem_addr_seen;

    fetch_frontend dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------
    // program image
    // ------------------------------
    function logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_jal(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [31:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // 0 plain, 1 jal, 2 conditional branch
    function automatic logic [1:0] kind_at(input logic [31:0] addr);
        case (addr)
            32'h1010, 32'h1170: return 2'd1;
            32'h1060, 32'h1068: return 2'd2;
            default:            return 2'd0;
        endcase
    endfunction

    function automatic logic [31:0] offset_at(input logic [31:0] addr);
        case (addr)
            32'h1010: return 32'h0000_0040;
            32'h1060: return 32'h0000_0100;
            32'h1068: return 32'hffff_fff8;
            32'h1170: return 32'hffff_fef0;
            default:  return 32'h0000_0004;
        endcase
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        case (kind_at(addr))
            2'd1:    return enc_jal(offset_at(addr));
            2'd2:    return enc_branch(offset_at(addr), (addr == 32'h1068) ? 3'b001 : 3'b000);
            // op-imm fill, every address bit above the word offset shows up
            default: return {addr[31:7] ^ {addr[6:2], addr[31:12]}, 7'b0010011};
        endcase
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic fetch_pkg::fetch_entry_t ref_entry(input logic [31:0] pc);
        fetch_pkg::fetch_entry_t e;
        logic [31:0]             off;
        int                      idx;
        logic                    taken;
        off   = offset_at(pc);
        idx   = int'(pc[5:2]);
        taken = 1'b0;
        if (kind_at(pc) == 2'd1) begin
            taken = 1'b1;
        end else if (kind_at(pc) == 2'd2) begin
            taken = model_valid[idx] ? (model_cnt[idx] >= 2) : off[31];
        end
        e.pc          = pc;
        e.instr       = mem_word(pc);
        e.pred_taken  = taken;
        e.pred_target = taken ? pc + off : pc + 32'd4;
        return e;
    endfunction

    function automatic void model_update(input logic [31:0] pc, input logic taken);
        int idx;
        idx = int'(pc[5:2]);
        if (!model_valid[idx]) begin
            model_cnt[idx]   = taken ? 2 : 1;
            model_valid[idx] = 1'b1;
        end else if (taken) begin
            model_cnt[idx] = (model_cnt[idx] < 3) ? model_cnt[idx] + 1 : 3;
        end else begin
            model_cnt[idx] = (model_cnt[idx] > 0) ? model_cnt[idx] - 1 : 0;
        end
    endfunction

    // memory answers one cycle after each request
    always begin
        @(posedge clk_i);
        mem_req_seen  = imem_req_o.req;
        mem_addr_seen = imem_req_o.addr;
        if (rst_ni && mem_req_seen && !first_req_done) begin
            first_req_done = 1'b1;
            assert (mem_addr_seen == boot_addr_i) else begin
                errors++;
                $display("ERR %0t imem_req_o.addr exp %h got %h",
                         $time, boot_addr_i, mem_addr_seen);
            end
        end
        #1;
        imem_rsp_i.valid = mem_req_seen;
        imem_rsp_i.data  = mem_word(mem_addr_seen);
    end

    // ------------------------------
    // compare
    // ------------------------------
    always @(posedge clk_i) begin
        fetch_pkg::addr_t nt;
        if (rst_ni) begin
            if ((resolved_branch_i.valid && resolved_branch_i.is_mispredict) ||
                eret_i || ex_valid_i || set_pc_commit_i) begin
                // later source in the priority list wins
                nt = exp_e.pc;
                if (resolved_branch_i.valid && resolved_branch_i.is_mispredict) begin
                    nt = resolved_branch_i.target;
                end
                if (eret_i) begin
                    nt = epc_i;
                end
                if (ex_valid_i) begin
                    nt = trap_vector_base_i;
                end
                if (set_pc_commit_i) begin
                    nt = pc_commit_i + 32'd4;
                end
                if (resolved_branch_i.valid && resolved_branch_i.is_branch) begin
                    model_update(resolved_branch_i.pc, resolved_branch_i.taken);
                end
                exp_e = ref_entry(nt);
            end else if (fetch_entry_valid_o && fetch_entry_ready_i) begin
                assert (fetch_entry_o.pc == exp_e.pc) else begin
                    errors++;
                    $display("ERR %0t fetch_entry_o.pc exp %h got %h",
                             $time, exp_e.pc, fetch_entry_o.pc);
                end
                assert (fetch_entry_o.instr == exp_e.instr) else begin
                    errors++;
                    $display("ERR %0t fetch_entry_o.instr exp %h got %h",
                             $time, exp_e.instr, fetch_entry_o.instr);
                end
                assert (fetch_entry_o.pred_taken == exp_e.pred_taken) else begin
                    errors++;
                    $display("ERR %0t fetch_entry_o.pred_taken exp %b got %b",
                             $time, exp_e.pred_taken, fetch_entry_o.pred_taken);
                end
                assert (fetch_entry_o.pred_target == exp_e.pred_target) else begin
                    errors++;
                    $display("ERR %0t fetch_entry_o.pred_target exp %h got %h",
                             $time, exp_e.pred_target, fetch_entry_o.pred_target);
                end
                xfer_count++;
                exp_e = ref_entry(exp_e.pred_target);
            end
        end
    end

    // ------------------------------
    // sequencing
    // ------------------------------
    task automatic wait_xfers(input int unsigned n, input int unsigned limit);
        int unsigned goal;
        int unsigned cycles;
        logic [31:0] r;
        goal   = xfer_count + n;
        cycles = 0;
        while (xfer_count < goal && cycles < limit) begin
            @(posedge clk_i);
            #1;
            r = rand_word();
            fetch_entry_ready_i = random_ready ? (r[31:30] != 2'b00) : 1'b1;
            cycles++;
        end
        fetch_entry_ready_i = 1'b1;
        if (xfer_count < goal) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout, only %0d of %0d fetch entries arrived",
                     n - (goal - xfer_count), n);
        end
    endtask

    // one cycle of back end redirect inputs, called 1 ns after an edge
    task automatic pulse_redirect(input fetch_pkg::bp_resolve_t rb, input logic eret,
                                  input logic ex, input logic commit);
        resolved_branch_i = rb;
        eret_i            = eret;
        ex_valid_i        = ex;
        set_pc_commit_i   = commit;
        @(posedge clk_i);
        #1;
        resolved_branch_i = '0;
        eret_i            = 1'b0;
        ex_valid_i        = 1'b0;
        set_pc_commit_i   = 1'b0;
    endtask

    task automatic finish_run();
        $display("errors %0d, checker failures %0d",
                 errors, dut.u_checker.fail_count);
        if (errors == 0 && dut.u_checker.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    initial begin
        fetch_pkg::bp_resolve_t rb;
        rst_ni              = 1'b0;
        boot_addr_i         = 32'h0000_1000;
        epc_i               = 32'h0000_3000;
        trap_vector_base_i  = 32'h0000_2000;
        pc_commit_i         = 32'h0000_4000;
        eret_i              = 1'b0;
        ex_valid_i          = 1'b0;
        set_pc_commit_i     = 1'b0;
        resolved_branch_i   = '0;
        imem_rsp_i          = '0;
        fetch_entry_ready_i = 1'b1;
        lcg_state           = 32'hc5d3832b;
        random_ready        = 1'b0;
        timed_out           = 1'b0;
        first_req_done      = 1'b0;
        xfer_count          = 0;
        errors              = 0;
        for (int i = 0; i < fetch_pkg::BHT_ENTRIES; i++) begin
            model_valid[i] = 1'b0;
            model_cnt[i]   = 0;
        end
        exp_e = ref_entry(boot_addr_i);
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // boot, sequential code, jal, static forward and backward branches
        wait_xfers(24, 200);

        // not taken update, forward branch stays not taken
        if (!timed_out) begin
            rb = '{valid: 1'b1, is_branch: 1'b1, taken: 1'b0, is_mispredict: 1'b1,
                   pc: 32'h1060, target: 32'h1064};
            pulse_redirect(rb, 1'b0, 1'b0, 1'b0);
            wait_xfers(12, 200);
        end
        // taken update lifts the counter to the taken half
        if (!timed_out) begin
            rb = '{valid: 1'b1, is_branch: 1'b1, taken: 1'b1, is_mispredict: 1'b1,
                   pc: 32'h1060, target: 32'h1160};
            pulse_redirect(rb, 1'b0, 1'b0, 1'b0);
            wait_xfers(16, 200);
        end
        // mispredict, eret and exception together, trap wins
        if (!timed_out) begin
            rb = '{valid: 1'b1, is_branch: 1'b0, taken: 1'b1, is_mispredict: 1'b1,
                   pc: 32'h1068, target: 32'h5000};
            pulse_redirect(rb, 1'b1, 1'b1, 1'b0);
            wait_xfers(10, 200);
        end
        // commit restart beats exception, then random back end stalls
        if (!timed_out) begin
            pulse_redirect('0, 1'b0, 1'b1, 1'b1);
            random_ready = 1'b1;
            wait_xfers(40, 600);
        end
        finish_run();
    end

endmodule

// File: files.f
fetch_pkg.sv
fetch_pc_gen.sv
cf_predict.sv
branch_history.sv
fetch_queue.sv
fetch_frontend.sv
fetch_frontend_checker.sv
tb_fetch_frontend.sv

// File: Makefile
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
